/* src/fetch_pkg.sv */
// ======================================================================
// Shared types for the instruction-fetch front end.
// Holds widths, the fetch PC view and the structs that pass between
// generator, address queue, controller, aligner and the outside.
// Every module pulls this in with a wildcard import in its header.
// ======================================================================

package fetch_pkg;

  // Instruction slots per fetch block
  localparam int FETCH_WIDTH = 4;
  localparam int PC_W        = 32;

  // PC field split: 16-byte block, 4 slots, word aligned
  localparam int BLK_W  = 28;
  localparam int SLOT_W = 2;
  localparam int OFF_W  = 2;

  // Default queue depth, also sizes the wrapped tag in the structs
  localparam int FAQ_DEPTH_DEFAULT = 8;
  localparam int FAQ_PTR_W         = $clog2(FAQ_DEPTH_DEFAULT) + 1;

  typedef logic [FAQ_PTR_W-1:0] faq_ptr_t;

  typedef struct packed {
    logic [BLK_W-1:0]  blk;
    logic [SLOT_W-1:0] slot;
    logic [OFF_W-1:0]  byte_off;
  } fetch_pc_fields_t;

  // One PC word, seen either as raw address or as block/slot/offset
  typedef union packed {
    logic [PC_W-1:0]  raw;
    fetch_pc_fields_t f;
  } fetch_pc_u;

  typedef struct packed {
    fetch_pc_u              pc;
    logic [FETCH_WIDTH-1:0] mask;
  } faq_entry_t;

  // Backend redirect; keep_idx is the first queue slot to discard
  typedef struct packed {
    logic            valid;
    logic [PC_W-1:0] target;
    faq_ptr_t        keep_idx;
  } redirect_t;

  typedef struct packed {
    logic             valid;
    logic [BLK_W-1:0] line_addr;
  } mem_req_t;

  typedef struct packed {
    logic                      valid;
    logic [FETCH_WIDTH*32-1:0] line;
  } mem_rsp_t;

  typedef struct packed {
    logic                         valid;
    fetch_pc_u                    pc;
    logic [FETCH_WIDTH-1:0]       mask;
    logic [FETCH_WIDTH-1:0][31:0] insn;
    faq_ptr_t                     tag;
  } fetch_pkt_t;

endpackage

/* src/fetch_pc_gen.sv */
// ======================================================================
// Sequential next-block PC generator.
// Pushes one block-aligned fetch address per cycle into the address
// queue, with a slot mask that starts at the current slot index.
// ======================================================================

`timescale 1ns/1ps

module fetch_pc_gen
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  redirect_t  redirect_i,
  input  logic       push_ready_i,
  output logic       push_valid_o,
  output faq_entry_t push_entry_o
);

  fetch_pc_u              pc_q;
  logic                   run_q;
  logic [FETCH_WIDTH-1:0] mask;

  // Slots from the current index to block end
  always_comb begin
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      mask[i] = (SLOT_W'(i) >= pc_q.f.slot);
    end
  end

  // Entry carries the block-aligned PC, slot info lives in the mask
  always_comb begin
    push_entry_o.pc.raw = {pc_q.f.blk, {(SLOT_W + OFF_W){1'b0}}};
    push_entry_o.mask   = mask;
  end

  assign push_valid_o = run_q;

  // PC counter; redirect wins over an accepted push
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q.raw <= '0;
      run_q    <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (redirect_i.valid) begin
        pc_q.raw <= redirect_i.target;
      end else if (push_valid_o && push_ready_i) begin
        // Next block always starts at slot 0
        pc_q.raw <= {pc_q.f.blk + BLK_W'(1), {(SLOT_W + OFF_W){1'b0}}};
      end
    end
  end

  // An unaligned redirect target must still leave at least one slot
  a_mask_nonzero: assert property (@(posedge clk) disable iff (rst_i)
    push_valid_o |-> |push_entry_o.mask);

endmodule

/* src/fetch_addr_queue.sv */
// ======================================================================
// Circular fetch address queue.
// Generator pushes at the tail, controller pops at the head once the
// packet is accepted. A redirect truncates the tail to its keep index,
// the head never moves on a redirect.
// ======================================================================

`timescale 1ns/1ps

module fetch_addr_queue
  import fetch_pkg::*;
#(
  parameter int FAQ_DEPTH = FAQ_DEPTH_DEFAULT
) (
  input  logic       clk,
  input  logic       rst_i,
  input  redirect_t  redirect_i,
  input  logic       push_valid_i,
  input  faq_entry_t push_entry_i,
  output logic       push_ready_o,
  input  logic       pop_i,
  output logic       head_valid_o,
  output faq_entry_t head_entry_o,
  output faq_ptr_t   head_tag_o,
  output logic       head_flushed_o
);

  localparam int AW = $clog2(FAQ_DEPTH);
  localparam int PW = AW + 1;

  faq_entry_t      mem_q [FAQ_DEPTH];
  logic [PW-1:0]   head_q;
  logic [PW-1:0]   tail_q;
  logic [PW-1:0]   keep;
  logic [PW-1:0]   keep_off;
  logic [PW-1:0]   occ;
  logic            empty;
  logic            full;
  logic            do_push;

  // ====================================================================
  // Status from wrapped pointers
  // ====================================================================
  assign empty = (head_q == tail_q);
  assign full  = (head_q[AW] != tail_q[AW]) && (head_q[AW-1:0] == tail_q[AW-1:0]);

  assign keep     = PW'(redirect_i.keep_idx);
  // Distances from head, for the range check
  assign keep_off = keep - head_q;
  assign occ      = tail_q - head_q;

  // Push dropped in a redirect cycle
  assign do_push = push_valid_i && !full && !redirect_i.valid;

  assign push_ready_o   = !full;
  assign head_valid_o   = !empty;
  assign head_entry_o   = mem_q[head_q[AW-1:0]];
  assign head_tag_o     = faq_ptr_t'(head_q);
  // Nothing kept means the head itself goes
  assign head_flushed_o = redirect_i.valid && (keep == head_q) && !empty;

  // ====================================================================
  // Storage and pointers
  // ====================================================================
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[tail_q[AW-1:0]] <= push_entry_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      // Truncating restore of the tail
      if (redirect_i.valid) begin
        tail_q <= keep;
      end else if (do_push) begin
        tail_q <= tail_q + PW'(1);
      end
      if (pop_i) begin
        head_q <= head_q + PW'(1);
      end
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
    pop_i |-> !empty);

  // Keep index must fall between head and tail inclusive
  a_keep_in_range: assert property (@(posedge clk) disable iff (rst_i)
    redirect_i.valid |-> (keep_off <= occ));

endmodule

/* src/fetch_ctrl_fsm.sv */
// ======================================================================
// Fetch controller FSM.
// Requests the cache line of the queue head, waits for the response,
// holds while decode has the packet and pops on accept. After a head
// flush with a request in flight it drops the stale response.
// ======================================================================

`timescale 1ns/1ps

module fetch_ctrl_fsm
  import fetch_pkg::*;
#(
  parameter int FAQ_DEPTH = FAQ_DEPTH_DEFAULT
) (
  input  logic       clk,
  input  logic       rst_i,
  input  redirect_t  redirect_i,
  input  logic       head_valid_i,
  input  faq_entry_t head_entry_i,
  input  logic       head_flushed_i,
  output mem_req_t   mem_req_o,
  input  logic       mem_req_ready_i,
  input  mem_rsp_t   mem_rsp_i,
  output logic       capture_o,
  input  logic       pkt_accept_i,
  output logic       pop_o
);

  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT,
    HOLD,
    DROP
  } state_e;

  state_e state_q;
  state_e state_d;

  // ====================================================================
  // Next state
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (head_valid_i && !head_flushed_i) begin
          state_d = REQ;
        end
      end
      REQ: begin
        // Flush in the accept cycle still leaves one response to eat
        if (head_flushed_i) begin
          state_d = mem_req_ready_i ? DROP : IDLE;
        end else if (mem_req_ready_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (head_flushed_i) begin
          state_d = mem_rsp_i.valid ? IDLE : DROP;
        end else if (mem_rsp_i.valid) begin
          state_d = HOLD;
        end
      end
      HOLD: begin
        if (head_flushed_i || pkt_accept_i) begin
          state_d = IDLE;
        end
      end
      DROP: begin
        if (mem_rsp_i.valid) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================================================================
  // Outputs
  // ====================================================================
  assign mem_req_o.valid     = (state_q == REQ);
  assign mem_req_o.line_addr = head_entry_i.pc.f.blk;

  // Response for a live head goes to the aligner
  assign capture_o = (state_q == WAIT) && mem_rsp_i.valid && !head_flushed_i;
  assign pop_o     = (state_q == HOLD) && pkt_accept_i && !head_flushed_i;

  // Request address held until the memory takes it
  a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
    (state_q == REQ) && !mem_req_ready_i && !head_flushed_i
    |=> $stable(mem_req_o.line_addr));

  // Redirect tag must be a valid wrapped pointer for this depth
  a_keep_fits: assert property (@(posedge clk) disable iff (rst_i)
    redirect_i.valid |-> (int'(redirect_i.keep_idx) < 2 * FAQ_DEPTH));

endmodule

/* src/fetch_resp_align.sv */
// ======================================================================
// Fetch response aligner.
// Captures the memory line with PC, mask and queue tag, zeroes the
// slots outside the mask and holds the packet until decode takes it.
// ======================================================================

`timescale 1ns/1ps

module fetch_resp_align
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  logic       capture_i,
  input  faq_entry_t head_entry_i,
  input  faq_ptr_t   head_tag_i,
  input  mem_rsp_t   mem_rsp_i,
  input  logic       flush_i,
  output fetch_pkt_t pkt_o,
  input  logic       pkt_ready_i,
  output logic       pkt_accept_o
);

  logic                         valid_q;
  fetch_pc_u                    pc_q;
  logic [FETCH_WIDTH-1:0]       mask_q;
  logic [FETCH_WIDTH-1:0][31:0] insn_q;
  faq_ptr_t                     tag_q;

  assign pkt_accept_o = valid_q && pkt_ready_i;

  always_comb begin
    pkt_o.valid = valid_q;
    pkt_o.pc    = pc_q;
    pkt_o.mask  = mask_q;
    pkt_o.insn  = insn_q;
    pkt_o.tag   = tag_q;
  end

  // Packet valid; flush beats capture
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (capture_i) begin
      valid_q <= 1'b1;
    end else if (pkt_accept_o) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, loaded only on capture
  always_ff @(posedge clk) begin
    if (capture_i) begin
      pc_q   <= head_entry_i.pc;
      mask_q <= head_entry_i.mask;
      tag_q  <= head_tag_i;
      for (int i = 0; i < FETCH_WIDTH; i++) begin
        // Masked-off slots read as zero
        insn_q[i] <= head_entry_i.mask[i] ? mem_rsp_i.line[i*32 +: 32] : 32'h0;
      end
    end
  end

  a_pkt_hold: assert property (@(posedge clk) disable iff (rst_i)
    pkt_o.valid && !pkt_ready_i && !flush_i |=> $stable(pkt_o));

endmodule

/* src/fetch_frontend_top.sv */
// ======================================================================
// Instruction-fetch front end, top level.
// Generator feeds the address queue, the controller fetches the head
// line from external memory and the aligner presents it to decode.
// ======================================================================

`timescale 1ns/1ps

module fetch_frontend_top
  import fetch_pkg::*;
#(
  parameter int FAQ_DEPTH = FAQ_DEPTH_DEFAULT
) (
  input  logic       clk,
  input  logic       rst_i,
  input  redirect_t  redirect_i,
  output mem_req_t   mem_req_o,
  input  logic       mem_req_ready_i,
  input  mem_rsp_t   mem_rsp_i,
  output fetch_pkt_t pkt_o,
  input  logic       pkt_ready_i
);

  // Generator to queue
  logic       push_valid;
  logic       push_ready;
  faq_entry_t push_entry;

  // Queue head side
  logic       head_valid;
  faq_entry_t head_entry;
  faq_ptr_t   head_tag;
  logic       head_flushed;

  // Controller and aligner handshakes
  logic       pop;
  logic       capture;
  logic       pkt_accept;

  fetch_pc_gen u_pc_gen (
    .clk          (clk),
    .rst_i        (rst_i),
    .redirect_i   (redirect_i),
    .push_ready_i (push_ready),
    .push_valid_o (push_valid),
    .push_entry_o (push_entry)
  );

  fetch_addr_queue #(
    .FAQ_DEPTH (FAQ_DEPTH)
  ) u_addr_queue (
    .clk            (clk),
    .rst_i          (rst_i),
    .redirect_i     (redirect_i),
    .push_valid_i   (push_valid),
    .push_entry_i   (push_entry),
    .push_ready_o   (push_ready),
    .pop_i          (pop),
    .head_valid_o   (head_valid),
    .head_entry_o   (head_entry),
    .head_tag_o     (head_tag),
    .head_flushed_o (head_flushed)
  );

  fetch_ctrl_fsm #(
    .FAQ_DEPTH (FAQ_DEPTH)
  ) u_ctrl_fsm (
    .clk             (clk),
    .rst_i           (rst_i),
    .redirect_i      (redirect_i),
    .head_valid_i    (head_valid),
    .head_entry_i    (head_entry),
    .head_flushed_i  (head_flushed),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .capture_o       (capture),
    .pkt_accept_i    (pkt_accept),
    .pop_o           (pop)
  );

  fetch_resp_align u_resp_align (
    .clk          (clk),
    .rst_i        (rst_i),
    .capture_i    (capture),
    .head_entry_i (head_entry),
    .head_tag_i   (head_tag),
    .mem_rsp_i    (mem_rsp_i),
    .flush_i      (head_flushed),
    .pkt_o        (pkt_o),
    .pkt_ready_i  (pkt_ready_i),
    .pkt_accept_o (pkt_accept)
  );

endmodule

/* testbench/tb_clk_gen.sv */
// ======================================================================
// Free-running testbench clock.
// Starts low and toggles every half period.
// ======================================================================

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period per toggle
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* testbench/tb_fetch_frontend.sv */
// ======================================================================
// Testbench for the instruction-fetch front end.
// Memory model with random latency, decode sink with random ready,
// redirect stimulus and a scoreboard of the expected block sequence.
// All DUT inputs change on the falling edge and immediate assertions check.
// ======================================================================

`timescale 1ns/1ps

module tb_fetch_frontend;
  import fetch_pkg::*;

  localparam int          FAQ_DEPTH  = 8;
  localparam int          TAG_MOD    = 2 * FAQ_DEPTH;
  localparam logic [31:0] WORD_KEY   = 32'h5a5a0000;
  localparam int          REDIR_WAIT = 200;

  logic       clk;
  logic       rst_i;
  redirect_t  redirect_i      = '0;
  mem_req_t   mem_req_o;
  logic       mem_req_ready_i = 1'b0;
  mem_rsp_t   mem_rsp_i       = '0;
  fetch_pkt_t pkt_o;
  logic       pkt_ready_i     = 1'b0;

  integer seed = 32'hc150b91e;

  // ====================================================================
  // State written by the falling-edge process only
  // ====================================================================
  int                     errors       = 0;
  int                     checks       = 0;
  int                     pkt_count    = 0;
  int                     mem_drops    = 0;
  int                     partial_seen = 0;
  int                     redir_served = 0;
  // Scoreboard of the next expected packet
  logic [31:0]            exp_pc       = 32'h0;
  logic [FETCH_WIDTH-1:0] exp_mask     = '1;
  faq_ptr_t               exp_tag      = '0;
  // Switch to the redirect target once the kept tags are through
  logic                   switch_pending = 1'b0;
  faq_ptr_t               switch_tag     = '0;
  logic [31:0]            switch_pc      = 32'h0;
  // Memory model with one request in flight
  logic                   mem_pending  = 1'b0;
  int                     mem_count    = 0;
  logic [BLK_W-1:0]       mem_addr     = '0;
  // Back-pressure tracking
  logic                   held_valid   = 1'b0;
  fetch_pkt_t             held_pkt     = '0;
  logic                   req_held     = 1'b0;
  logic [BLK_W-1:0]       req_addr     = '0;
  logic                   redir_flush  = 1'b0;

  // ====================================================================
  // State written by the test sequence only
  // ====================================================================
  logic        started            = 1'b0;
  int          sink_mode          = 0;
  int          redir_issue        = 0;
  int          redir_keep_n       = 0;
  logic        redir_need_pending = 1'b0;
  logic [31:0] redir_target       = 32'h0;
  logic        timed_out          = 1'b0;
  int          seq_errors         = 0;
  int          seq_checks         = 0;
  int          test_num           = 1;
  int          tests_failed       = 0;
  int          test_err_base      = 0;

  tb_clk_gen #(.PERIOD_NS(20)) u_clk_gen (.clk_o(clk));

  fetch_frontend_top #(
    .FAQ_DEPTH (FAQ_DEPTH)
  ) dut_i (
    .clk             (clk),
    .rst_i           (rst_i),
    .redirect_i      (redirect_i),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i),
    .pkt_o           (pkt_o),
    .pkt_ready_i     (pkt_ready_i)
  );

  // Each word is its byte address XOR the key
  function automatic logic [31:0] mem_word(input logic [BLK_W-1:0] line, input int slot);
    mem_word = ({line, 4'b0000} + 32'(4 * slot)) ^ WORD_KEY;
  endfunction

  // Slots from the PC's slot index to block end
  function automatic logic [FETCH_WIDTH-1:0] mask_from(input logic [31:0] pc);
    logic [FETCH_WIDTH-1:0] m;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      m[i] = (i >= int'(pc[3:2]));
    end
    return m;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (got == exp) else begin
      $display("ERR %s exp %h got %h", name, exp, got);
      errors++;
    end
  endtask

  // Compare an accepted packet with the scoreboard and advance one block
  task automatic check_packet();
    logic [31:0] word;
    if (switch_pending && exp_tag == switch_tag) begin
      exp_pc         = {switch_pc[31:4], 4'b0000};
      exp_mask       = mask_from(switch_pc);
      switch_pending = 1'b0;
    end
    check_value("pkt_o.pc", exp_pc, pkt_o.pc.raw);
    check_value("pkt_o.mask", 32'(exp_mask), 32'(pkt_o.mask));
    check_value("pkt_o.tag", 32'(exp_tag), 32'(pkt_o.tag));
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      word = exp_mask[i] ? mem_word(exp_pc[31:4], i) : 32'h0;
      check_value($sformatf("pkt_o.insn[%0d]", i), word, pkt_o.insn[i]);
    end
    if (pkt_o.mask != '1) begin
      partial_seen++;
    end
    exp_pc   = exp_pc + 32'd16;
    exp_mask = '1;
    exp_tag  = faq_ptr_t'((int'(exp_tag) + 1) % TAG_MOD);
    pkt_count++;
  endtask

  // ====================================================================
  // Falling-edge memory model, redirect and decode sink
  // ====================================================================
  always @(negedge clk) begin
    if (started) begin
      // Response at the end of the latency count
      mem_rsp_i.valid = 1'b0;
      if (mem_pending) begin
        mem_count--;
        if (mem_count == 0) begin
          mem_pending     = 1'b0;
          mem_rsp_i.valid = 1'b1;
          for (int i = 0; i < FETCH_WIDTH; i++) begin
            mem_rsp_i.line[i*32 +: 32] = mem_word(mem_addr, i);
          end
        end
      end
      // Held packet and held request must not move
      if (held_valid) begin
        checks++;
        assert (pkt_o.valid && pkt_o == held_pkt) else begin
          $display("ERR pkt_o held exp %h got %h", held_pkt, pkt_o);
          errors++;
        end
      end
      if (req_held && mem_req_o.valid) begin
        check_value("mem_req_o.line_addr", {4'h0, req_addr}, {4'h0, mem_req_o.line_addr});
      end
      // One-cycle redirect with the keep index counted from the head
      redirect_i  = '0;
      redir_flush = 1'b0;
      if (redir_served != redir_issue && (!redir_need_pending || mem_pending)) begin
        redirect_i.valid    = 1'b1;
        redirect_i.target   = redir_target;
        redirect_i.keep_idx = faq_ptr_t'((int'(exp_tag) + redir_keep_n) % TAG_MOD);
        switch_pending      = 1'b1;
        switch_tag          = redirect_i.keep_idx;
        switch_pc           = redir_target;
        redir_flush         = (redir_keep_n == 0);
        redir_served++;
      end
      // Decode sink
      case (sink_mode)
        0:       pkt_ready_i = 1'b1;
        1:       pkt_ready_i = ($random(seed) & 3) != 0;
        default: pkt_ready_i = 1'b0;
      endcase
      if (redirect_i.valid) begin
        pkt_ready_i = 1'b0;
      end
      if (pkt_o.valid && pkt_ready_i) begin
        check_packet();
      end
      held_valid = pkt_o.valid && !pkt_ready_i && !redir_flush;
      held_pkt   = pkt_o;
      // Request ready drops at random
      mem_req_ready_i = !mem_pending && (($random(seed) & 3) != 0);
      if (mem_req_o.valid && !mem_req_ready_i) begin
        mem_drops++;
      end
      req_held = mem_req_o.valid && !mem_req_ready_i;
      req_addr = mem_req_o.line_addr;
      if (mem_req_o.valid && mem_req_ready_i) begin
        mem_pending = 1'b1;
        mem_addr    = mem_req_o.line_addr;
        mem_count   = 1 + ($random(seed) & 3);
      end
    end
  end

  // ====================================================================
  // Test sequence helpers
  // ====================================================================
  task automatic wait_packets(input int n, input string what);
    int target;
    int cycles;
    target = pkt_count + n;
    cycles = 0;
    while (!timed_out && pkt_count < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > 50 * n + 100) begin
        $display("Timeout waiting for %0d packets during %s", n, what);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic issue_redirect(input logic [31:0] target, input int keep_n,
                                input logic need_pending);
    int cycles;
    redir_target       = target;
    redir_keep_n       = keep_n;
    redir_need_pending = need_pending;
    redir_issue++;
    cycles = 0;
    while (!timed_out && redir_served != redir_issue) begin
      @(posedge clk);
      cycles++;
      if (cycles > REDIR_WAIT) begin
        $display("Timeout waiting for the redirect to be applied");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    seq_checks++;
    assert (ok) else begin
      $display("Check failed: %s", what);
      seq_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int now_err;
    now_err = errors + seq_errors;
    if (now_err == test_err_base && !timed_out) begin
      $display("Test %0d %s: PASS", test_num, name);
    end else begin
      $display("Test %0d %s: FAIL, %0d errors", test_num, name, now_err - test_err_base);
      tests_failed++;
    end
    test_num++;
    test_err_base = now_err;
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int partial_base;
    int drops_base;
    rst_i = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    // Outputs idle while in reset
    check_flag(!mem_req_o.valid, "mem_req_o.valid low in reset");
    check_flag(!pkt_o.valid, "pkt_o.valid low in reset");
    rst_i = 1'b0;
    @(posedge clk);
    started = 1'b1;

    // In-order blocks from PC 0
    sink_mode = 0;
    wait_packets(8, "in-order fetch");
    finish_test("in-order fetch after reset");

    // Decode stalls until the queue fills and then drains
    sink_mode = 2;
    repeat (20) @(posedge clk);
    sink_mode = 1;
    wait_packets(12, "back-pressure drain");
    finish_test("back-pressure");

    // Unaligned redirect keeping two entries
    sink_mode = 2;
    repeat (12) @(posedge clk);
    partial_base = partial_seen;
    issue_redirect(32'h0000_1238, 2, 1'b0);
    sink_mode = 1;
    wait_packets(8, "unaligned redirect");
    check_flag(partial_seen == partial_base + 1, "one partial block after redirect");
    finish_test("unaligned redirect");

    // Head flush while its request is in flight
    sink_mode = 0;
    issue_redirect(32'h0000_2000, 0, 1'b1);
    wait_packets(6, "head flush");
    finish_test("flush with outstanding request");

    // Tags wrap twice under random latency and ready
    sink_mode  = 1;
    drops_base = mem_drops;
    wait_packets(2 * TAG_MOD, "tag wrap");
    check_flag(mem_drops > drops_base, "memory ready dropped during request");
    finish_test("tag sequence");

    $display("Tests %0d, failed %0d, checks %0d, error count %0d", test_num - 1,
             tests_failed, checks + seq_checks, errors + seq_errors);
    if (errors + seq_errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_addr_queue.sv
src/fetch_ctrl_fsm.sv
src/fetch_resp_align.sv
src/fetch_frontend_top.sv
testbench/tb_clk_gen.sv
testbench/tb_fetch_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch front-end testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fetch_frontend -f flist.f -o tb_fetch_frontend

./obj_dir/tb_fetch_frontend | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
